// ==== qa_tester_settings.svh ====
`ifndef QA_TESTER_SETTINGS_SVH
`define QA_TESTER_SETTINGS_SVH

// Width of one host channel message
`define QA_UMF_WIDTH 128

// Width of the SOURCE message count carried by a CSR request
`define QA_COUNT_WIDTH 31

// First pattern sent in SOURCE mode
`define QA_SOURCE_INIT 1

// Constant folded into every pattern step
// Each step is (pattern << 1) ^ this value
`define QA_SOURCE_XOR 12345

`endif

// ==== qa_tester_pkg.sv ====
package qa_tester_pkg;

    // Test mode of the node
    // Encoding matches the CSR request field, so a raw request casts directly
    typedef enum logic [1:0]
    {
        NORMAL   = 2'd0,
        // Consume host messages, answer once at the end
        SINK     = 2'd1,
        // Send a counted pattern stream to the host
        SOURCE   = 2'd2,
        // Echo host messages back to the host
        LOOPBACK = 2'd3
    } t_test_mode;

    // Debug snapshot of the channel strobes
    // Packed MSB first, 6 bits in total
    typedef struct packed
    {
        // Driver to-client side has a message
        logic       rx_rdy;
        // Message taken from the driver rx FIFO
        logic       rx_enable;
        // Driver from-client side has space
        logic       tx_rdy;
        // Message written into the driver tx FIFO
        logic       tx_enable;
        // Mode in effect during the sampled cycle
        t_test_mode mode;
    } t_tester_dbg;

endpackage

// ==== qa_tester_if.sv ====
`include "qa_tester_settings.svh"

// Control bundle shared by the tester blocks
interface tester_ctrl_if;
    import qa_tester_pkg::*;

    // Current test mode, owned by the mode FSM
    t_test_mode                 mode;
    // End of the running test, decided by the router
    logic                       test_done;
    // SOURCE pattern before the last-message flag is merged in
    logic [`QA_UMF_WIDTH-1:0]   source_data;
    // Count has reached its final message
    logic                       source_last;

    modport fsm
    (
        output mode,
        input  test_done
    );

    modport route
    (
        input  mode,
        input  source_data,
        input  source_last,
        output test_done
    );

    modport source
    (
        input  mode,
        output source_data,
        output source_last
    );

    modport status
    (
        input  mode,
        input  test_done
    );

endinterface

// ==== qa_tester_mode_fsm.sv ====
module qa_tester_mode_fsm
(
    input  logic                     clk,
    input  logic                     resetb,
    // Raw request, nonzero for exactly one cycle
    input  qa_tester_pkg::t_test_mode csr_test_mode,
    tester_ctrl_if.fsm               ctrl
);
    import qa_tester_pkg::*;

    // Mode register and its next value
    t_test_mode mode_q;
    t_test_mode mode_next;

    // A request is present whenever the field is not NORMAL
    logic csr_req;

    assign csr_req = (csr_test_mode != NORMAL);

    // Next-state decision
    always_comb
    begin
        mode_next = mode_q;

        // A new request takes priority over a test ending in the same cycle
        if (csr_req)
        begin
            mode_next = csr_test_mode;
        end
        else if (ctrl.test_done)
        begin
            // Test complete, give the channel back to the client
            mode_next = NORMAL;
        end
    end

    // State register
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            mode_q <= NORMAL;
        end
        else
        begin
            mode_q <= mode_next;
        end
    end

    // Mode is broadcast to route, source and status
    assign ctrl.mode = mode_q;

endmodule

// ==== qa_source_gen.sv ====
`include "qa_tester_settings.svh"

module qa_source_gen
(
    input  logic                        clk,
    // Number of messages to send, captured with the request
    input  logic [`QA_COUNT_WIDTH-1:0]  csr_test_count,
    // Host side can take a message this cycle
    input  logic                        tx_rdy,
    tester_ctrl_if.source               ctrl
);
    import qa_tester_pkg::*;

    localparam logic [`QA_UMF_WIDTH-1:0]  PATTERN_INIT = `QA_SOURCE_INIT;
    localparam logic [`QA_UMF_WIDTH-1:0]  PATTERN_XOR  = `QA_SOURCE_XOR;
    localparam logic [`QA_COUNT_WIDTH-1:0] COUNT_LAST  = 1;

    // Messages still to send, including the current one
    logic [`QA_COUNT_WIDTH-1:0] count_q;
    // Pattern of the message currently offered
    logic [`QA_UMF_WIDTH-1:0]   pattern_q;
    logic                       in_source;

    assign in_source = (ctrl.mode == SOURCE);

    // Count and pattern registers
    // Outside SOURCE they track the request every cycle,
    // so the value in the request cycle is what the test starts from
    always_ff @(posedge clk)
    begin
        if (!in_source)
        begin
            count_q   <= csr_test_count;
            pattern_q <= PATTERN_INIT;
        end
        else if (tx_rdy)
        begin
            // One message leaves on every cycle with tx_rdy
            count_q   <= count_q - 1'b1;
            // Predictable shift-XOR sequence the host can check
            pattern_q <= (pattern_q << 1) ^ PATTERN_XOR;
        end
    end

    assign ctrl.source_data = pattern_q;

    // Count of 0 wraps and is never flagged until it comes round to 1
    assign ctrl.source_last = (count_q == COUNT_LAST);

endmodule

// ==== qa_tester_route.sv ====
`include "qa_tester_settings.svh"

module qa_tester_route
(
    // Client side of the to-client FIFO
    output logic [`QA_UMF_WIDTH-1:0] rx_fifo_data,
    output logic                     rx_fifo_rdy,
    input  logic                     rx_fifo_enable,

    // Client side of the from-client FIFO
    input  logic [`QA_UMF_WIDTH-1:0] tx_fifo_data,
    output logic                     tx_fifo_rdy,
    input  logic                     tx_fifo_enable,

    // Driver side of the to-client FIFO
    input  logic [`QA_UMF_WIDTH-1:0] rx_data,
    input  logic                     rx_rdy,
    output logic                     rx_enable,

    // Driver side of the from-client FIFO
    output logic [`QA_UMF_WIDTH-1:0] tx_data,
    input  logic                     tx_rdy,
    output logic                     tx_enable,

    tester_ctrl_if.route             ctrl
);
    import qa_tester_pkg::*;

    // End of test for the current cycle
    logic done;

    // Client always sees the driver data, it is ignored while rdy is low
    assign rx_fifo_data = rx_data;

    always_comb
    begin
        // NORMAL routing unless a test mode overrides it
        rx_fifo_rdy = rx_rdy;
        tx_fifo_rdy = tx_rdy;
        rx_enable   = rx_fifo_enable;
        tx_data     = tx_fifo_data;
        tx_enable   = tx_fifo_enable;
        done        = 1'b0;

        case (ctrl.mode)
            SINK:
            begin
                // Client is locked out
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Take a message only when the answer could be sent
                rx_enable   = rx_rdy && tx_rdy;
                // Bit 0 marks the final message of the test
                done        = rx_enable && rx_data[0];
                // Single reply carrying a 1
                tx_data     = {{(`QA_UMF_WIDTH-1){1'b0}}, rx_enable};
                tx_enable   = done;
            end

            SOURCE:
            begin
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Drain whatever the host sends meanwhile
                rx_enable   = rx_rdy;
                // Pattern with bit 0 reused as the last-message flag
                tx_data     = {ctrl.source_data[`QA_UMF_WIDTH-1:1], ctrl.source_last};
                tx_enable   = tx_rdy;
                done        = tx_rdy && ctrl.source_last;
            end

            LOOPBACK:
            begin
                rx_fifo_rdy = 1'b0;
                tx_fifo_rdy = 1'b0;
                // Accept only what can be echoed in the same cycle
                rx_enable   = rx_rdy && tx_rdy;
                tx_data     = rx_data;
                tx_enable   = rx_enable;
                done        = rx_enable && rx_data[0];
            end

            default:
            begin
                // NORMAL keeps the straight-through defaults
                done = 1'b0;
            end
        endcase
    end

    assign ctrl.test_done = done;

endmodule

// ==== qa_tester_status.sv ====
module qa_tester_status
(
    input  logic                       clk,
    input  logic                       resetb,
    // Routed driver strobes
    input  logic                       rx_rdy,
    input  logic                       rx_enable,
    input  logic                       tx_rdy,
    input  logic                       tx_enable,
    tester_ctrl_if.status              ctrl,
    output qa_tester_pkg::t_tester_dbg dbg_tester,
    output logic [15:0]                tests_done
);
    import qa_tester_pkg::*;

    // Snapshot lags the strobes by one cycle
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            dbg_tester <= '0;
        end
        else
        begin
            dbg_tester.rx_rdy    <= rx_rdy;
            dbg_tester.rx_enable <= rx_enable;
            dbg_tester.tx_rdy    <= tx_rdy;
            dbg_tester.tx_enable <= tx_enable;
            dbg_tester.mode      <= ctrl.mode;
        end
    end

    // Completed tests, wraps at 16 bits
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            tests_done <= '0;
        end
        else if (ctrl.test_done)
        begin
            tests_done <= tests_done + 1'b1;
        end
    end

endmodule

// ==== qa_drv_tester.sv ====
`include "qa_tester_settings.svh"

module qa_drv_tester
(
    input  logic                        clk,
    input  logic                        resetb,

    // CSR test request, valid while mode is nonzero
    input  logic [1:0]                  csr_test_mode,
    input  logic [`QA_COUNT_WIDTH-1:0]  csr_test_count,

    // Client side of the to-client FIFO
    output logic [`QA_UMF_WIDTH-1:0]    rx_fifo_data,
    output logic                        rx_fifo_rdy,
    input  logic                        rx_fifo_enable,

    // Client side of the from-client FIFO
    input  logic [`QA_UMF_WIDTH-1:0]    tx_fifo_data,
    output logic                        tx_fifo_rdy,
    input  logic                        tx_fifo_enable,

    // Driver side of the to-client FIFO
    input  logic [`QA_UMF_WIDTH-1:0]    rx_data,
    input  logic                        rx_rdy,
    output logic                        rx_enable,

    // Driver side of the from-client FIFO
    output logic [`QA_UMF_WIDTH-1:0]    tx_data,
    input  logic                        tx_rdy,
    output logic                        tx_enable,

    // Status outputs
    output logic [5:0]                  dbg_tester,
    output logic [15:0]                 tests_done
);
    import qa_tester_pkg::*;

    t_test_mode  csr_mode;
    t_tester_dbg dbg_snap;

    // Raw CSR field uses the mode encoding directly
    assign csr_mode = t_test_mode'(csr_test_mode);

    tester_ctrl_if ctrl ();

    qa_tester_mode_fsm mode_fsm0
    (
        .clk           (clk),
        .resetb        (resetb),
        .csr_test_mode (csr_mode),
        .ctrl          (ctrl.fsm)
    );

    qa_source_gen source_gen0
    (
        .clk            (clk),
        .csr_test_count (csr_test_count),
        .tx_rdy         (tx_rdy),
        .ctrl           (ctrl.source)
    );

    qa_tester_route route0
    (
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rdy    (rx_fifo_rdy),
        .rx_fifo_enable (rx_fifo_enable),
        .tx_fifo_data   (tx_fifo_data),
        .tx_fifo_rdy    (tx_fifo_rdy),
        .tx_fifo_enable (tx_fifo_enable),
        .rx_data        (rx_data),
        .rx_rdy         (rx_rdy),
        .rx_enable      (rx_enable),
        .tx_data        (tx_data),
        .tx_rdy         (tx_rdy),
        .tx_enable      (tx_enable),
        .ctrl           (ctrl.route)
    );

    // Status samples the routed enables, not the client ones
    qa_tester_status status0
    (
        .clk        (clk),
        .resetb     (resetb),
        .rx_rdy     (rx_rdy),
        .rx_enable  (rx_enable),
        .tx_rdy     (tx_rdy),
        .tx_enable  (tx_enable),
        .ctrl       (ctrl.status),
        .dbg_tester (dbg_snap),
        .tests_done (tests_done)
    );

    // Flattened for the status manager
    assign dbg_tester = dbg_snap;

endmodule

// ==== qa_drv_tester_sva.sv ====
`include "qa_tester_settings.svh"

module qa_drv_tester_sva
(
    input logic                         clk,
    input logic                         resetb,
    input logic [1:0]                   csr_test_mode,
    input logic [`QA_COUNT_WIDTH-1:0]   csr_test_count,
    input logic [`QA_UMF_WIDTH-1:0]     rx_fifo_data,
    input logic                         rx_fifo_rdy,
    input logic                         rx_fifo_enable,
    input logic [`QA_UMF_WIDTH-1:0]     tx_fifo_data,
    input logic                         tx_fifo_rdy,
    input logic                         tx_fifo_enable,
    input logic [`QA_UMF_WIDTH-1:0]     rx_data,
    input logic                         rx_rdy,
    input logic                         rx_enable,
    input logic [`QA_UMF_WIDTH-1:0]     tx_data,
    input logic                         tx_rdy,
    input logic                         tx_enable,
    input logic [5:0]                   dbg_tester,
    input logic [15:0]                  tests_done
);
    import qa_tester_pkg::*;

    localparam int W = `QA_UMF_WIDTH;
    localparam logic [`QA_COUNT_WIDTH-1:0] LAST_LEFT = 1;

    // Raised by any failing assertion, watched by the testbench
    logic fail_seen = 1'b0;

    // Reference model state
    t_test_mode                 exp_mode;
    logic [`QA_COUNT_WIDTH-1:0] src_left;
    logic [W-1:0]               src_pattern;
    logic [15:0]                exp_tests;
    logic [5:0]                 exp_dbg;

    // Expected values for the current cycle
    logic                       exp_last;
    logic                       exp_done;
    logic                       exp_rx_enable;
    logic                       exp_tx_enable;
    logic [1:0]                 exp_client_rdy;
    logic [W-1:0]               exp_tx_data;

    assign exp_last = (src_left == LAST_LEFT);

    always_comb
    begin
        // LOOPBACK values, the other modes override them
        exp_client_rdy = 2'b00;
        exp_rx_enable  = rx_rdy && tx_rdy;
        exp_tx_enable  = exp_rx_enable;
        exp_tx_data    = rx_data;
        exp_done       = exp_rx_enable && rx_data[0];
        if (exp_mode == NORMAL)
        begin
            exp_client_rdy = {rx_rdy, tx_rdy};
            exp_rx_enable  = rx_fifo_enable;
            exp_tx_enable  = tx_fifo_enable;
            exp_tx_data    = tx_fifo_data;
            exp_done       = 1'b0;
        end
        else if (exp_mode == SINK)
        begin
            // One reply of value 1 on the closing message
            exp_tx_enable = exp_done;
            exp_tx_data   = {{(W-1){1'b0}}, exp_rx_enable};
        end
        else if (exp_mode == SOURCE)
        begin
            exp_rx_enable = rx_rdy;
            exp_tx_enable = tx_rdy;
            exp_done      = tx_rdy && exp_last;
            exp_tx_data   = {src_pattern[W-1:1], exp_last};
        end
    end

    // Mode, completed tests and the delayed snapshot
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            exp_mode  <= NORMAL;
            exp_tests <= '0;
            exp_dbg   <= '0;
        end
        else
        begin
            // Request wins over a test ending in the same cycle
            if (csr_test_mode != 2'd0)
                exp_mode <= t_test_mode'(csr_test_mode);
            else if (exp_done)
                exp_mode <= NORMAL;
            exp_tests <= exp_tests + {15'd0, exp_done};
            exp_dbg   <= {rx_rdy, exp_rx_enable, tx_rdy, exp_tx_enable, exp_mode};
        end
    end

    // Messages left and the shift-XOR pattern of SOURCE mode
    always_ff @(posedge clk)
    begin
        if (exp_mode != SOURCE)
        begin
            src_left    <= csr_test_count;
            src_pattern <= W'(`QA_SOURCE_INIT);
        end
        else if (tx_rdy)
        begin
            src_left    <= src_left - LAST_LEFT;
            src_pattern <= {src_pattern[W-2:0], 1'b0} ^ W'(`QA_SOURCE_XOR);
        end
    end

    a_rx_enable: assert property (@(posedge clk) disable iff (!resetb)
        rx_enable == exp_rx_enable)
        else
        begin
            fail_seen = 1'b1;
            $error("error t=%0t rx_enable expected %0b actual %0b", $time, exp_rx_enable,
                   rx_enable);
        end

    a_tx_enable: assert property (@(posedge clk) disable iff (!resetb)
        tx_enable == exp_tx_enable)
        else
        begin
            fail_seen = 1'b1;
            $error("error t=%0t tx_enable expected %0b actual %0b", $time, exp_tx_enable,
                   tx_enable);
        end

    a_tx_data: assert property (@(posedge clk) disable iff (!resetb)
        tx_data == exp_tx_data)
        else
        begin
            fail_seen = 1'b1;
            $error("error t=%0t tx_data expected %h actual %h", $time, exp_tx_data, tx_data);
        end

    // Both client rdy outputs in one check
    a_client_rdy: assert property (@(posedge clk) disable iff (!resetb)
        {rx_fifo_rdy, tx_fifo_rdy} == exp_client_rdy)
        else
        begin
            fail_seen = 1'b1;
            $error("error t=%0t rx_fifo_rdy,tx_fifo_rdy expected %b actual %b", $time,
                   exp_client_rdy, {rx_fifo_rdy, tx_fifo_rdy});
        end

    a_rx_fifo_data: assert property (@(posedge clk) disable iff (!resetb)
        rx_fifo_data == rx_data)
        else
        begin
            fail_seen = 1'b1;
            $error("error t=%0t rx_fifo_data expected %h actual %h", $time, rx_data,
                   rx_fifo_data);
        end

    // Also covers the cleared snapshot right after reset
    a_dbg_tester: assert property (@(posedge clk) disable iff (!resetb)
        dbg_tester == exp_dbg)
        else
        begin
            fail_seen = 1'b1;
            $error("error t=%0t dbg_tester expected %b actual %b", $time, exp_dbg, dbg_tester);
        end

    a_tests_done: assert property (@(posedge clk) disable iff (!resetb)
        tests_done == exp_tests)
        else
        begin
            fail_seen = 1'b1;
            $error("error t=%0t tests_done expected %0d actual %0d", $time, exp_tests,
                   tests_done);
        end

endmodule

bind qa_drv_tester qa_drv_tester_sva sva0 (.*);

// ==== tb_qa_drv_tester.sv ====
`include "qa_tester_settings.svh"

module tb_qa_drv_tester;
    import qa_tester_pkg::*;

    localparam int W          = `QA_UMF_WIDTH;
    localparam int WAIT_LIMIT = 1000;

    logic                       clk;
    logic                       resetb;
    logic [1:0]                 csr_test_mode;
    logic [`QA_COUNT_WIDTH-1:0] csr_test_count;
    logic [W-1:0]               rx_fifo_data;
    logic                       rx_fifo_rdy;
    logic                       rx_fifo_enable;
    logic [W-1:0]               tx_fifo_data;
    logic                       tx_fifo_rdy;
    logic                       tx_fifo_enable;
    logic [W-1:0]               rx_data;
    logic                       rx_rdy;
    logic                       rx_enable;
    logic [W-1:0]               tx_data;
    logic                       tx_rdy;
    logic                       tx_enable;
    logic [5:0]                 dbg_tester;
    logic [15:0]                tests_done;
    logic [31:0]                rng_state;

    qa_drv_tester dut0 (.*);

    always #4 clk = ~clk;

    // Bound checker flags a failure, stop on the next falling edge
    always @(negedge clk)
    begin
        if (dut0.sva0.fail_seen)
        begin
            $display("TB FAILED");
            $fatal(1, "assertion failure flagged by the bound checker");
        end
    end

    // Xorshift step on the shared generator state
    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TB FAILED");
        $fatal(1, "wait loop timed out");
    endtask

    // One cycle of random traffic, with a CSR request when req_mode is nonzero
    task automatic drive_cycle(input logic [1:0] req_mode, input logic [30:0] req_count,
                               input logic allow_last);
        logic [31:0] r;
        logic [W-1:0] msg;
        r   = next_random();
        msg = {next_random(), next_random(), next_random(), next_random()};
        // Bit 0 closes SINK and LOOPBACK tests, keep it rare
        msg[0] = allow_last && (r[7:5] == 3'd0);
        @(posedge clk);
        rx_data        <= msg;
        tx_fifo_data   <= {next_random(), next_random(), next_random(), next_random()};
        rx_rdy         <= r[0];
        tx_rdy         <= r[1];
        rx_fifo_enable <= r[2];
        tx_fifo_enable <= r[3];
        csr_test_mode  <= req_mode;
        // Junk count outside the request cycle
        csr_test_count <= (req_mode != 2'd0) ? req_count : r[31:1];
    endtask

    // Snapshot must show NORMAL again once the test is over
    task automatic wait_normal();
        int cycles;
        cycles = 0;
        while (dbg_tester[1:0] != 2'd0 && cycles < 10)
        begin
            drive_cycle(2'd0, 31'd0, 1'b0);
            @(negedge clk);
            cycles++;
        end
        if (dbg_tester[1:0] != 2'd0)
            report_timeout("the mode to return to NORMAL");
    endtask

    // Request one test and wait until tests_done counts it
    task automatic run_test(input logic [1:0] mode, input logic [30:0] count);
        logic [15:0] start;
        int cycles;
        @(negedge clk);
        start = tests_done;
        drive_cycle(mode, count, 1'b0);
        @(negedge clk);
        cycles = 0;
        while (tests_done == start && cycles < WAIT_LIMIT)
        begin
            // No closing bit for the first few cycles
            drive_cycle(2'd0, 31'd0, cycles > 6);
            @(negedge clk);
            cycles++;
        end
        if (tests_done == start)
            report_timeout("tests_done to count the finished test");
        wait_normal();
    endtask

    initial
    begin
        logic [31:0] r;
        rng_state      = 32'h2d3a_c731;
        clk            = 1'b0;
        resetb         = 1'b0;
        csr_test_mode  = 2'd0;
        csr_test_count = '0;
        rx_fifo_enable = 1'b0;
        tx_fifo_data   = '0;
        tx_fifo_enable = 1'b0;
        rx_data        = '0;
        rx_rdy         = 1'b0;
        tx_rdy         = 1'b0;
        repeat (3) @(posedge clk);
        resetb <= 1'b1;
        // Pass-through under random traffic
        repeat (30) drive_cycle(2'd0, 31'd0, 1'b1);
        for (int i = 0; i < 2; i++)
        begin
            run_test(SINK, 31'd0);
            r = next_random();
            run_test(SOURCE, 31'(r % 20) + 31'd1);
            run_test(LOOPBACK, 31'd0);
            repeat (10) drive_cycle(2'd0, 31'd0, 1'b1);
        end
        // Reset in the middle of an open LOOPBACK test
        drive_cycle(LOOPBACK, 31'd0, 1'b0);
        repeat (5) drive_cycle(2'd0, 31'd0, 1'b0);
        resetb <= 1'b0;
        repeat (3) drive_cycle(2'd0, 31'd0, 1'b0);
        resetb <= 1'b1;
        repeat (20) drive_cycle(2'd0, 31'd0, 1'b1);
        @(negedge clk);
        if (dut0.sva0.fail_seen)
        begin
            $display("TB FAILED");
            $fatal(1, "assertion failure flagged by the bound checker");
        end
        else
        begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

// ==== flist.f ====
+incdir+.
qa_tester_pkg.sv
qa_tester_if.sv
qa_tester_mode_fsm.sv
qa_source_gen.sv
qa_tester_route.sv
qa_tester_status.sv
qa_drv_tester.sv
qa_drv_tester_sva.sv
tb_qa_drv_tester.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_qa_drv_tester -f flist.f

# The log decides pass or fail, so a nonzero exit of the run is tolerated here
./obj_dir/Vtb_qa_drv_tester +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
